// File: source/axi_stats_pkg.sv
package axi_stats_pkg;

  localparam int STAT_WIDTH = 32;
  localparam int STAT_COUNT = 13;

  typedef logic [STAT_WIDTH-1:0] stat_t;

  // readout order follows the id value
  typedef enum logic [7:0] {
    AW_BURST_CNT = 8'd0,
    AW_DEPTH_MAX = 8'd1,
    AW_LEN_MIN   = 8'd2,
    AW_LEN_MAX   = 8'd3,
    AW_BYTES_SUM = 8'd4,
    AW_BYTES_MIN = 8'd5,
    AW_BYTES_MAX = 8'd6,
    W_BURST_CNT  = 8'd7,
    W_DEPTH_MAX  = 8'd8,
    W_BEAT_CNT   = 8'd9,
    W_BYTES_SUM  = 8'd10,
    W_BYTES_MIN  = 8'd11,
    W_BYTES_MAX  = 8'd12
  } stat_id_t;

  typedef struct packed {
    logic       valid;
    logic       ready;
    logic [7:0] len;
    logic [2:0] size;
  } aw_chan_t;

  // strobe is carried on its own port, its width is a parameter
  typedef struct packed {
    logic valid;
    logic ready;
    logic last;
  } w_chan_t;

  typedef struct packed {
    logic valid;
    logic ready;
  } b_chan_t;

  typedef struct packed {
    stat_t burst_cnt;
    stat_t len_min;
    stat_t len_max;
    stat_t bytes_sum;
    stat_t bytes_min;
    stat_t bytes_max;
  } aw_result_t;

  typedef struct packed {
    stat_t burst_cnt;
    stat_t beat_cnt;
    stat_t bytes_sum;
    stat_t bytes_min;
    stat_t bytes_max;
  } w_result_t;

  typedef struct packed {
    stat_t aw_depth_max;
    stat_t w_depth_max;
  } depth_result_t;

  typedef struct packed {
    stat_id_t id;
    stat_t    val;
    logic     last;
  } stat_item_t;

endpackage

// File: source/stat_minmax.sv
`timescale 1ns/1ps

module stat_minmax import axi_stats_pkg::*; #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clear,
  input  logic             en,
  input  logic [WIDTH-1:0] val,
  output logic [WIDTH-1:0] min,
  output logic [WIDTH-1:0] max,
  output stat_t            sum
);

  // set once the first sample has been folded in
  logic seen;

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      min  <= '1;
      max  <= '0;
      sum  <= '0;
      seen <= 1'b0;
    end else if (en) begin
      if (val < min) begin
        min <= val;
      end
      if (val > max) begin
        max <= val;
      end
      // wraps at the stat width
      sum  <= sum + STAT_WIDTH'(val);
      seen <= 1'b1;
    end
  end

  // running extremes stay ordered over any sample sequence
  a_min_le_max: assert property (
    @(posedge clk) disable iff (!rst_n)
    seen |-> (min <= max)
  );

endmodule

// File: source/aw_stats.sv
`timescale 1ns/1ps

module aw_stats import axi_stats_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clear,
  input  aw_chan_t   aw,
  output aw_result_t result
);

  logic       aw_hs;
  stat_t      burst_cnt;
  stat_t      bytes;
  logic [7:0] len_min;
  logic [7:0] len_max;
  stat_t      bytes_min;
  stat_t      bytes_max;
  stat_t      bytes_sum;

  assign aw_hs = aw.valid && aw.ready;

  // bytes in the burst are beats times bytes per beat
  assign bytes = (STAT_WIDTH'(aw.len) + stat_t'(1)) << aw.size;

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      burst_cnt <= '0;
    end else if (aw_hs) begin
      burst_cnt <= burst_cnt + stat_t'(1);
    end
  end

  stat_minmax #(
    .WIDTH(8)
  ) u_len (
    .clk  (clk),
    .rst_n(rst_n),
    .clear(clear),
    .en   (aw_hs),
    .val  (aw.len),
    .min  (len_min),
    .max  (len_max),
    .sum  ()
  );

  stat_minmax #(
    .WIDTH(STAT_WIDTH)
  ) u_bytes (
    .clk  (clk),
    .rst_n(rst_n),
    .clear(clear),
    .en   (aw_hs),
    .val  (bytes),
    .min  (bytes_min),
    .max  (bytes_max),
    .sum  (bytes_sum)
  );

  assign result.burst_cnt = burst_cnt;
  assign result.len_min   = STAT_WIDTH'(len_min);
  assign result.len_max   = STAT_WIDTH'(len_max);
  assign result.bytes_sum = bytes_sum;
  assign result.bytes_min = bytes_min;
  assign result.bytes_max = bytes_max;

endmodule

// File: source/w_stats.sv
`timescale 1ns/1ps

module w_stats import axi_stats_pkg::*; #(
  parameter int STRB_WIDTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear,
  input  w_chan_t               w,
  input  logic [STRB_WIDTH-1:0] strb,
  output w_result_t             result
);

  // wide enough to hold a full strobe count
  localparam int CNT_WIDTH = $clog2(STRB_WIDTH + 1);

  logic                 w_hs;
  logic [CNT_WIDTH-1:0] ones;
  logic [CNT_WIDTH-1:0] bytes_min;
  logic [CNT_WIDTH-1:0] bytes_max;
  stat_t                bytes_sum;
  stat_t                beat_cnt;
  stat_t                burst_cnt;

  assign w_hs = w.valid && w.ready;

  // population count of the strobe
  always_comb begin
    ones = '0;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      ones = ones + CNT_WIDTH'(strb[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      beat_cnt  <= '0;
      burst_cnt <= '0;
    end else if (w_hs) begin
      beat_cnt <= beat_cnt + stat_t'(1);
      if (w.last) begin
        burst_cnt <= burst_cnt + stat_t'(1);
      end
    end
  end

  stat_minmax #(
    .WIDTH(CNT_WIDTH)
  ) u_bytes (
    .clk  (clk),
    .rst_n(rst_n),
    .clear(clear),
    .en   (w_hs),
    .val  (ones),
    .min  (bytes_min),
    .max  (bytes_max),
    .sum  (bytes_sum)
  );

  assign result.burst_cnt = burst_cnt;
  assign result.beat_cnt  = beat_cnt;
  assign result.bytes_sum = bytes_sum;
  assign result.bytes_min = STAT_WIDTH'(bytes_min);
  assign result.bytes_max = STAT_WIDTH'(bytes_max);

endmodule

// File: source/depth_tracker.sv
`timescale 1ns/1ps

module depth_tracker import axi_stats_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          clear,
  input  aw_chan_t      aw,
  input  w_chan_t       w,
  input  b_chan_t       b,
  output depth_result_t result
);

  logic  aw_hs;
  logic  w_last_hs;
  logic  b_hs;
  stat_t aw_cnt;
  stat_t w_cnt;
  stat_t aw_peak;
  stat_t w_peak;

  assign aw_hs     = aw.valid && aw.ready;
  assign w_last_hs = w.valid && w.ready && w.last;
  assign b_hs      = b.valid && b.ready;

  // aw outstanding runs from address accept to response,
  // w outstanding from the last data beat to response
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      aw_cnt  <= '0;
      w_cnt   <= '0;
      aw_peak <= '0;
      w_peak  <= '0;
    end else begin
      aw_cnt <= aw_cnt + stat_t'(aw_hs) - stat_t'(b_hs);
      w_cnt  <= w_cnt + stat_t'(w_last_hs) - stat_t'(b_hs);
      // peaks follow the registered counts a cycle late
      if (aw_cnt > aw_peak) begin
        aw_peak <= aw_cnt;
      end
      if (w_cnt > w_peak) begin
        w_peak <= w_cnt;
      end
    end
  end

  assign result.aw_depth_max = aw_peak;
  assign result.w_depth_max  = w_peak;

  // a response needs both an accepted address and a completed data burst
  a_b_needs_aw: assert property (
    @(posedge clk) disable iff (!rst_n)
    b_hs |-> (aw_cnt != '0)
  );

  a_b_needs_w: assert property (
    @(posedge clk) disable iff (!rst_n)
    b_hs |-> (w_cnt != '0)
  );

endmodule

// File: source/stat_reader.sv
`timescale 1ns/1ps

module stat_reader import axi_stats_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start,
  input  aw_result_t    aw_res,
  input  w_result_t     w_res,
  input  depth_result_t depth_res,
  output stat_item_t    item,
  output logic          item_valid,
  input  logic          item_ready
);

  localparam stat_id_t LAST_ID = stat_id_t'(STAT_COUNT - 1);

  typedef enum logic {
    ST_IDLE,
    ST_ITER
  } state_t;

  state_t   state;
  stat_id_t idx;
  stat_t    sel_val;
  logic     load;

  // output register is empty or being drained this cycle
  assign load = (state == ST_ITER) && (!item_valid || item_ready);

  always_comb begin
    case (idx)
      AW_BURST_CNT: sel_val = aw_res.burst_cnt;
      AW_DEPTH_MAX: sel_val = depth_res.aw_depth_max;
      AW_LEN_MIN:   sel_val = aw_res.len_min;
      AW_LEN_MAX:   sel_val = aw_res.len_max;
      AW_BYTES_SUM: sel_val = aw_res.bytes_sum;
      AW_BYTES_MIN: sel_val = aw_res.bytes_min;
      AW_BYTES_MAX: sel_val = aw_res.bytes_max;
      W_BURST_CNT:  sel_val = w_res.burst_cnt;
      W_DEPTH_MAX:  sel_val = depth_res.w_depth_max;
      W_BEAT_CNT:   sel_val = w_res.beat_cnt;
      W_BYTES_SUM:  sel_val = w_res.bytes_sum;
      W_BYTES_MIN:  sel_val = w_res.bytes_min;
      W_BYTES_MAX:  sel_val = w_res.bytes_max;
      default:      sel_val = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      idx        <= AW_BURST_CNT;
      item_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_ITER;
            idx   <= AW_BURST_CNT;
          end
        end
        ST_ITER: begin
          if (load) begin
            idx <= stat_id_t'(idx + 8'd1);
            if (idx == LAST_ID) begin
              state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase

      if (load) begin
        item_valid <= 1'b1;
      end else if (item_ready) begin
        item_valid <= 1'b0;
      end
    end
  end

  // value is sampled when the item is loaded, not when consumed
  always_ff @(posedge clk) begin
    if (load) begin
      item.id   <= idx;
      item.val  <= sel_val;
      item.last <= (idx == LAST_ID);
    end
  end

  a_item_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (item_valid && !item_ready) |=> (item_valid && $stable(item))
  );

endmodule

// File: source/axi_wr_stats_top.sv
`timescale 1ns/1ps

module axi_wr_stats_top import axi_stats_pkg::*; #(
  parameter int STRB_WIDTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear,
  input  logic                  start,
  input  aw_chan_t              aw,
  input  w_chan_t               w,
  input  logic [STRB_WIDTH-1:0] strb,
  input  b_chan_t               b,
  output stat_item_t            item,
  output logic                  item_valid,
  input  logic                  item_ready
);

  aw_result_t    aw_res;
  w_result_t     w_res;
  depth_result_t depth_res;

  aw_stats u_aw_stats (
    .clk   (clk),
    .rst_n (rst_n),
    .clear (clear),
    .aw    (aw),
    .result(aw_res)
  );

  w_stats #(
    .STRB_WIDTH(STRB_WIDTH)
  ) u_w_stats (
    .clk   (clk),
    .rst_n (rst_n),
    .clear (clear),
    .w     (w),
    .strb  (strb),
    .result(w_res)
  );

  depth_tracker u_depth (
    .clk   (clk),
    .rst_n (rst_n),
    .clear (clear),
    .aw    (aw),
    .w     (w),
    .b     (b),
    .result(depth_res)
  );

  // readout is not affected by clear, only the values it samples
  stat_reader u_reader (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .aw_res    (aw_res),
    .w_res     (w_res),
    .depth_res (depth_res),
    .item      (item),
    .item_valid(item_valid),
    .item_ready(item_ready)
  );

endmodule

// File: testbench/axi_wr_stats_tb.sv
`timescale 1ns/1ps

module axi_wr_stats_tb import axi_stats_pkg::*; ();

  localparam int STRB_WIDTH   = 4;
  localparam int READ_TIMEOUT = 400;

  logic                  clk;
  logic                  rst_n;
  logic                  clear;
  logic                  start;
  aw_chan_t              aw;
  w_chan_t               w;
  logic [STRB_WIDTH-1:0] strb;
  b_chan_t               b;
  stat_item_t            item;
  logic                  item_valid;
  logic                  item_ready;

  // reference model, indexed by statistic id
  stat_t       exp_stat [STAT_COUNT];
  stat_t       aw_out;
  stat_t       w_out;
  logic [31:0] rng_state;
  int          errors;

  axi_wr_stats_top #(
    .STRB_WIDTH(STRB_WIDTH)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .start     (start),
    .aw        (aw),
    .w         (w),
    .strb      (strb),
    .b         (b),
    .item      (item),
    .item_valid(item_valid),
    .item_ready(item_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic reset_model();
    for (int i = 0; i < STAT_COUNT; i++) begin
      exp_stat[i] = '0;
    end
    // minima start at all ones of their own field
    exp_stat[AW_LEN_MIN]   = 32'd255;
    exp_stat[AW_BYTES_MIN] = 32'hffff_ffff;
    // a count of up to 4 strobe bits sits in a 3-bit field
    exp_stat[W_BYTES_MIN]  = 32'd7;
    aw_out = '0;
    w_out  = '0;
  endtask

  task automatic fold_min_max(input stat_t v, input stat_id_t min_id, input stat_id_t max_id);
    if (v < exp_stat[min_id]) begin
      exp_stat[min_id] = v;
    end
    if (v > exp_stat[max_id]) begin
      exp_stat[max_id] = v;
    end
  endtask

  task automatic update_model(input aw_chan_t a, input w_chan_t d,
                              input logic [STRB_WIDTH-1:0] s, input b_chan_t r);
    stat_t bytes;
    stat_t ones;
    if (a.valid && a.ready) begin
      bytes = (stat_t'(a.len) + 32'd1) << a.size;
      exp_stat[AW_BURST_CNT] += 32'd1;
      exp_stat[AW_BYTES_SUM] += bytes;
      fold_min_max(stat_t'(a.len), AW_LEN_MIN, AW_LEN_MAX);
      fold_min_max(bytes, AW_BYTES_MIN, AW_BYTES_MAX);
      aw_out += 32'd1;
    end
    if (d.valid && d.ready) begin
      ones = '0;
      for (int i = 0; i < STRB_WIDTH; i++) begin
        ones += stat_t'(s[i]);
      end
      exp_stat[W_BEAT_CNT]  += 32'd1;
      exp_stat[W_BYTES_SUM] += ones;
      fold_min_max(ones, W_BYTES_MIN, W_BYTES_MAX);
      if (d.last) begin
        exp_stat[W_BURST_CNT] += 32'd1;
        w_out += 32'd1;
      end
    end
    if (r.valid && r.ready) begin
      aw_out -= 32'd1;
      w_out  -= 32'd1;
    end
    // peaks only need to be right once the readout starts
    if (aw_out > exp_stat[AW_DEPTH_MAX]) begin
      exp_stat[AW_DEPTH_MAX] = aw_out;
    end
    if (w_out > exp_stat[W_DEPTH_MAX]) begin
      exp_stat[W_DEPTH_MAX] = w_out;
    end
  endtask

  task automatic drive_traffic(input int cycles, input bit allow_b);
    logic [31:0]           r;
    aw_chan_t              a;
    w_chan_t               d;
    b_chan_t               rsp;
    logic [STRB_WIDTH-1:0] s;
    for (int n = 0; n < cycles; n++) begin
      r       = next_random();
      a.valid = r[0];
      a.ready = r[1];
      a.len   = r[15:8];
      a.size  = r[18:16];
      d.valid = r[2];
      d.ready = r[3];
      d.last  = r[4];
      s       = r[20 +: STRB_WIDTH];
      rsp.valid = r[5];
      // a response needs an outstanding address and a finished data burst
      rsp.ready = allow_b && r[6] && (aw_out != 0) && (w_out != 0);
      @(posedge clk);
      aw   <= a;
      w    <= d;
      strb <= s;
      b    <= rsp;
      update_model(a, d, s, rsp);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      aw   <= '0;
      w    <= '0;
      strb <= '0;
      b    <= '0;
    end
  endtask

  task automatic clear_stats();
    @(posedge clk);
    clear <= 1'b1;
    reset_model();
    @(posedge clk);
    clear <= 1'b0;
  endtask

  task automatic read_stats(input string name, input bit random_ready);
    int          got;
    int          waited;
    logic [31:0] r;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    got    = 0;
    waited = 0;
    while (got < STAT_COUNT && waited < READ_TIMEOUT) begin
      @(negedge clk);
      if (item_valid && item_ready) begin
        if (int'(item.id) != got) begin
          $display("[FAIL] %s id: expected %0d, actual %0d", name, got, item.id);
          errors++;
        end
        if (item.val !== exp_stat[got]) begin
          $display("[FAIL] %s value of id %0d: expected %0d, actual %0d",
                   name, got, exp_stat[got], item.val);
          errors++;
        end
        if (item.last !== (got == STAT_COUNT - 1)) begin
          $display("[FAIL] %s last of id %0d: expected %0d, actual %0d",
                   name, got, (got == STAT_COUNT - 1), item.last);
          errors++;
        end
        got++;
      end
      @(posedge clk);
      r = next_random();
      item_ready <= random_ready ? r[0] : 1'b1;
      waited++;
    end
    item_ready <= 1'b1;
    if (got < STAT_COUNT) begin
      $display("%s timed out after %0d of %0d items", name, got, STAT_COUNT);
      errors++;
    end
    @(negedge clk);
    if (item_valid) begin
      $display("%s: item_valid still high after the last item", name);
      errors++;
    end
  endtask

  initial begin
    rng_state  = 32'd66604;
    errors     = 0;
    rst_n      = 1'b0;
    clear      = 1'b0;
    start      = 1'b0;
    aw         = '0;
    w          = '0;
    strb       = '0;
    b          = '0;
    item_ready = 1'b1;
    reset_model();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    idle_cycles(2);
    @(negedge clk);
    if (item_valid) begin
      $display("item_valid is high right after reset");
      errors++;
    end
    read_stats("reset_state", 1'b0);

    drive_traffic(200, 1'b1);
    idle_cycles(2);
    read_stats("random_traffic", 1'b0);

    // build up outstanding bursts before any response
    drive_traffic(40, 1'b0);
    drive_traffic(80, 1'b1);
    idle_cycles(2);
    read_stats("depth_peak", 1'b0);

    idle_cycles(2);
    read_stats("random_ready", 1'b1);

    idle_cycles(2);
    clear_stats();
    drive_traffic(150, 1'b1);
    idle_cycles(2);
    read_stats("after_clear", 1'b1);

    $display("readout checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: list.f
source/axi_stats_pkg.sv
source/stat_minmax.sv
source/aw_stats.sv
source/w_stats.sv
source/depth_tracker.sv
source/stat_reader.sv
source/axi_wr_stats_top.sv
testbench/axi_wr_stats_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = axi_wr_stats_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
